// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= exec_unit_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/100ps
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(abspath $(BIN)) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	// Free running, 50% duty
	always begin
		#(PERIOD_NS / 2);
		clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// ==== dv/exec_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exec_unit_tb;

	localparam int VW = `EXEC_VALUE_W;
	localparam int RESET_CYCLES = 3;
	localparam int IDLE_CYCLES = 4;
	// Issues per test: latency, reg ops, imm ops, multiply, mix
	localparam int N_ISSUES = 1 + 48 + 72 + 204 + 200;
	localparam int N_TESTS = 5;
	localparam int MAX_CYCLES = RESET_CYCLES + IDLE_CYCLES + N_ISSUES
		+ N_TESTS * (`EXEC_LATENCY + 3) + 20;

	typedef struct packed {
		exec_pkg::result_t res;
		logic [31:0] due;
	} expect_t;

	logic clk_g;
	logic rst_i;
	logic issue_stb_i;
	exec_pkg::issue_t issue_i;
	logic result_stb_o;
	exec_pkg::result_t result_o;

	expect_t exp_q[$];
	expect_t cur;
	integer seed = 34;
	int cycle = 0;
	int n_issued = 0;
	int check_cnt = 0;
	int err_cnt = 0;
	int misc_err = 0;
	int chk_mark = 0;
	int err_mark = 0;

	clk_gen #(.PERIOD_NS(100)) clk_gen_i (.clk_o(clk_g));

	exec_unit exec_unit_i (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.issue_stb_i  (issue_stb_i),
		.issue_i      (issue_i),
		.result_stb_o (result_stb_o),
		.result_o     (result_o)
	);

	// ==============================
	// Reference model
	// ==============================

	function automatic exec_pkg::value_t sext_imm(input logic [`EXEC_IMM_W-1:0] imm);
		return {{(VW - `EXEC_IMM_W){imm[`EXEC_IMM_W-1]}}, imm};
	endfunction

	// Three-way compare: -1, 0 or 1
	function automatic exec_pkg::value_t cmp3(input logic lt, input logic eq);
		if (lt)
			return '1;
		else if (eq)
			return '0;
		else
			return exec_pkg::value_t'(1);
	endfunction

	function automatic exec_pkg::result_t ref_result(input exec_pkg::issue_t iss);
		exec_pkg::result_t r;
		exec_pkg::value_t a;
		exec_pkg::value_t b;
		exec_pkg::value_t c;
		exec_pkg::value_t imm;
		logic [2*VW-1:0] prod;
		logic mul_op;
		logic mul_signed;
		logic mul_high;
		a = iss.a;
		b = iss.b;
		c = iss.c;
		imm = sext_imm(iss.insn.i_form.imm);
		r.tag = iss.insn.i_form.rt;
		r.val = '0;
		r.ovf = 1'b0;
		mul_op = 1'b0;
		mul_signed = 1'b1;
		mul_high = 1'b0;
		case (iss.insn.i_form.opcode)
			exec_pkg::R2: begin
				case (iss.insn.r_form.func)
					exec_pkg::ADD: r.val = a + b + c;
					exec_pkg::SUB: r.val = a - b;
					exec_pkg::AND: r.val = a & b & c;
					exec_pkg::OR:  r.val = a | b | c;
					exec_pkg::XOR: r.val = a ^ b ^ c;
					exec_pkg::MUX: r.val = (a & b) | (~a & c);
					exec_pkg::MUL: mul_op = 1'b1;
					exec_pkg::MULH: begin
						mul_op = 1'b1;
						mul_high = 1'b1;
					end
					exec_pkg::MULU: begin
						mul_op = 1'b1;
						mul_signed = 1'b0;
					end
					exec_pkg::MULUH: begin
						mul_op = 1'b1;
						mul_signed = 1'b0;
						mul_high = 1'b1;
					end
					default: r.val = '0;
				endcase
			end
			exec_pkg::ADDI:  r.val = a + imm;
			exec_pkg::SUBFI: r.val = imm - a;
			exec_pkg::ANDI:  r.val = a & imm;
			exec_pkg::ORI:   r.val = a | imm;
			exec_pkg::XORI:  r.val = a ^ imm;
			exec_pkg::CMPI:  r.val = cmp3($signed(a) < $signed(imm), a == imm);
			exec_pkg::CMPUI: r.val = cmp3(a < imm, a == imm);
			exec_pkg::SLTI:  r.val = exec_pkg::value_t'($signed(a) < $signed(imm));
			exec_pkg::SEQI:  r.val = exec_pkg::value_t'(a == imm);
			exec_pkg::MULI: begin
				mul_op = 1'b1;
				b = imm;
			end
			exec_pkg::MULUI: begin
				mul_op = 1'b1;
				mul_signed = 1'b0;
				b = imm;
			end
			default: r.val = '0;
		endcase
		// Two's complement product on double width operands
		if (mul_op) begin
			if (mul_signed)
				prod = {{VW{a[VW-1]}}, a} * {{VW{b[VW-1]}}, b};
			else
				prod = {{VW{1'b0}}, a} * {{VW{1'b0}}, b};
			r.val = mul_high ? prod[2*VW-1:VW] : prod[VW-1:0];
			if (mul_signed)
				r.ovf = prod[2*VW-1:VW] != {VW{prod[VW-1]}};
			else
				r.ovf = prod[2*VW-1:VW] != '0;
		end
		return r;
	endfunction

	// ==============================
	// Stimulus helpers
	// ==============================

	function automatic exec_pkg::value_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [`EXEC_IMM_W-1:0] rand_imm(input logic neg);
		logic [31:0] r;
		r = $random(seed);
		r[`EXEC_IMM_W-1] = neg;
		return r[`EXEC_IMM_W-1:0];
	endfunction

	function automatic exec_pkg::value_t edge_val(input int k);
		case (k)
			0: return '0;
			1: return '1;
			2: return {1'b1, {(VW-1){1'b0}}};
			3: return {1'b0, {(VW-1){1'b1}}};
			4: return exec_pkg::value_t'(1);
			default: return rand_word();
		endcase
	endfunction

	function automatic logic [`EXEC_IMM_W-1:0] edge_imm(input int k);
		case (k)
			0: return '0;
			1: return '1;
			2: return {1'b1, {(`EXEC_IMM_W-1){1'b0}}};
			3: return 19'd1;
			default: return rand_imm(k[0]);
		endcase
	endfunction

	function automatic exec_pkg::func_e pick_alu_func(input int k);
		case (k)
			0: return exec_pkg::ADD;
			1: return exec_pkg::SUB;
			2: return exec_pkg::AND;
			3: return exec_pkg::OR;
			4: return exec_pkg::XOR;
			default: return exec_pkg::MUX;
		endcase
	endfunction

	function automatic exec_pkg::func_e pick_mul_func(input int k);
		case (k)
			0: return exec_pkg::MUL;
			1: return exec_pkg::MULH;
			2: return exec_pkg::MULU;
			default: return exec_pkg::MULUH;
		endcase
	endfunction

	function automatic exec_pkg::opcode_e pick_imm_op(input int k);
		case (k)
			0: return exec_pkg::ADDI;
			1: return exec_pkg::SUBFI;
			2: return exec_pkg::ANDI;
			3: return exec_pkg::ORI;
			4: return exec_pkg::XORI;
			5: return exec_pkg::CMPI;
			6: return exec_pkg::CMPUI;
			7: return exec_pkg::SLTI;
			default: return exec_pkg::SEQI;
		endcase
	endfunction

	function automatic exec_pkg::issue_t make_r(input exec_pkg::func_e f,
		input exec_pkg::value_t a, input exec_pkg::value_t b, input exec_pkg::value_t c);
		exec_pkg::issue_t iss;
		iss.insn.r_form.rsvd = '0;
		iss.insn.r_form.func = f;
		iss.insn.r_form.rt = '0;
		iss.insn.r_form.opcode = exec_pkg::R2;
		iss.a = a;
		iss.b = b;
		iss.c = c;
		return iss;
	endfunction

	// Unused b and c get noise, the result must not depend on them
	function automatic exec_pkg::issue_t make_i(input exec_pkg::opcode_e op,
		input logic [`EXEC_IMM_W-1:0] imm, input exec_pkg::value_t a,
		input exec_pkg::value_t noise);
		exec_pkg::issue_t iss;
		iss.insn.i_form.imm = imm;
		iss.insn.i_form.rt = '0;
		iss.insn.i_form.opcode = op;
		iss.a = a;
		iss.b = noise;
		iss.c = ~noise;
		return iss;
	endfunction

	// Tag is the issue count, so order is visible in the results
	task automatic send(input exec_pkg::issue_t iss_in);
		exec_pkg::issue_t iss;
		expect_t e;
		iss = iss_in;
		iss.insn.i_form.rt = exec_pkg::tag_t'(n_issued);
		@(posedge clk_g);
		issue_stb_i <= 1'b1;
		issue_i <= iss;
		e.res = ref_result(iss);
		e.due = 32'(cycle + 1 + `EXEC_LATENCY);
		exp_q.push_back(e);
		n_issued++;
	endtask

	// Wait for the last results, at most a little past the latency
	task automatic end_test(input string name);
		int waited;
		waited = 0;
		@(posedge clk_g);
		issue_stb_i <= 1'b0;
		while (exp_q.size() != 0 && waited < `EXEC_LATENCY + 2) begin
			@(negedge clk_g);
			waited++;
		end
		$display("Test %s done: %0d checks, %0d errors", name,
			check_cnt - chk_mark, err_cnt - err_mark);
		chk_mark = check_cnt;
		err_mark = err_cnt;
	endtask

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("Fail %s: expected 0x%h, actual 0x%h", name, exp, act);
		end
	endtask

	// ==============================
	// Compare and timeout
	// ==============================

	always @(posedge clk_g) begin
		cycle <= cycle + 1;
	end

	always @(posedge clk_g) begin
		if (!rst_i && result_stb_o) begin
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("Result strobe in cycle %0d with no instruction in flight", cycle);
			end else begin
				cur = exp_q.pop_front();
				check_value("result_o.tag", 64'(cur.res.tag), 64'(result_o.tag));
				check_value("result_o.val", cur.res.val, result_o.val);
				check_value("result_o.ovf", 64'(cur.res.ovf), 64'(result_o.ovf));
				check_value("result_stb_o cycle", 64'(cur.due), 64'(cycle));
			end
		end
	end

	always @(posedge clk_g) begin
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, results still missing", cycle);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ==============================
	// Tests
	// ==============================

	task automatic test_latency();
		// Nothing may come out before the first issue
		repeat (IDLE_CYCLES) @(posedge clk_g);
		send(make_i(exec_pkg::ADDI, rand_imm(1'b1), rand_word(), rand_word()));
		end_test("latency");
	endtask

	task automatic test_reg_ops();
		for (int i = 0; i < 48; i++)
			send(make_r(pick_alu_func(i % 6), rand_word(), rand_word(), rand_word()));
		end_test("reg_ops");
	endtask

	task automatic test_imm_ops();
		logic [`EXEC_IMM_W-1:0] imm;
		exec_pkg::value_t a;
		for (int i = 0; i < 72; i++) begin
			imm = rand_imm(i[3]);
			// Less, equal and greater around the immediate
			case ((i / 9) % 4)
				0: a = rand_word();
				1: a = sext_imm(imm) - 1;
				2: a = sext_imm(imm);
				default: a = sext_imm(imm) + 1;
			endcase
			send(make_i(pick_imm_op(i % 9), imm, a, rand_word()));
		end
		end_test("imm_ops");
	endtask

	task automatic test_mul();
		for (int i = 0; i < 144; i++)
			send(make_r(pick_mul_func(i / 36), edge_val(i % 6), edge_val((i / 6) % 6),
				rand_word()));
		for (int i = 0; i < 60; i++)
			send(make_i((i < 30) ? exec_pkg::MULI : exec_pkg::MULUI, edge_imm((i / 6) % 5),
				edge_val(i % 6), rand_word()));
		end_test("multiply");
	endtask

	task automatic test_mix();
		logic [31:0] r;
		exec_pkg::issue_t iss;
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			if (r[3:0] < 4'd6)
				iss = make_r(pick_alu_func(int'(r[3:0])), rand_word(), rand_word(), rand_word());
			else if (r[3:0] < 4'd10)
				iss = make_r(pick_mul_func(int'(r[3:0]) - 6), rand_word(), rand_word(),
					rand_word());
			else if (r[3:0] < 4'd13)
				iss = make_i(pick_imm_op(int'(r[11:4]) % 9), rand_imm(r[12]), rand_word(),
					rand_word());
			else
				iss = make_i(r[13] ? exec_pkg::MULI : exec_pkg::MULUI, rand_imm(r[12]),
					rand_word(), rand_word());
			send(iss);
		end
		end_test("mix");
	endtask

	initial begin
		rst_i <= 1'b1;
		issue_stb_i <= 1'b0;
		issue_i <= '0;
		repeat (RESET_CYCLES) @(posedge clk_g);
		rst_i <= 1'b0;
		test_latency();
		test_reg_ops();
		test_imm_ops();
		test_mul();
		test_mix();
		if (exp_q.size() != 0) begin
			misc_err++;
			$display("%0d issued instructions never produced a result", exp_q.size());
		end
		$display("Done: %0d issues, %0d checks, %0d errors", n_issued, check_cnt,
			err_cnt + misc_err);
		if (err_cnt + misc_err == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== include/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Operand and result width
`define EXEC_VALUE_W 64

// Destination tag, taken from the rt field
`define EXEC_TAG_W 6

// Instruction word and its immediate field
`define EXEC_INSN_W 32
`define EXEC_IMM_W 19

// Cycles from issue strobe to result strobe
`define EXEC_LATENCY 5

`endif

// ==== rtl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

	`include "exec_settings.svh"

	typedef logic [`EXEC_VALUE_W-1:0] value_t;
	typedef logic [`EXEC_TAG_W-1:0] tag_t;

	// ==============================
	// Instruction encodings
	// ==============================

	typedef enum logic [6:0] {
		R2    = 7'h02,
		ADDI  = 7'h04,
		SUBFI = 7'h05,
		ANDI  = 7'h08,
		ORI   = 7'h09,
		XORI  = 7'h0A,
		CMPI  = 7'h0B,
		CMPUI = 7'h0C,
		SLTI  = 7'h0D,
		SEQI  = 7'h0E,
		MULI  = 7'h10,
		MULUI = 7'h11
	} opcode_e;

	// Function field of the register form
	typedef enum logic [5:0] {
		ADD   = 6'h04,
		SUB   = 6'h05,
		AND   = 6'h08,
		OR    = 6'h09,
		XOR   = 6'h0A,
		MUX   = 6'h0C,
		MUL   = 6'h10,
		MULH  = 6'h11,
		MULU  = 6'h12,
		MULUH = 6'h13
	} func_e;

	typedef struct packed {
		logic [`EXEC_INSN_W-`EXEC_TAG_W-14:0] rsvd;
		func_e func;
		tag_t rt;
		opcode_e opcode;
	} r_form_t;

	typedef struct packed {
		logic [`EXEC_IMM_W-1:0] imm;
		tag_t rt;
		opcode_e opcode;
	} i_form_t;

	// Opcode and rt sit at the same bits in both views
	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} insn_u;

	// ==============================
	// Stage payloads
	// ==============================

	typedef struct packed {
		insn_u insn;
		value_t a;
		value_t b;
		value_t c;
	} issue_t;

	// ALU operations after decode
	typedef enum logic [3:0] {
		ALU_ZERO,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MUX,
		ALU_CMP,
		ALU_CMPU,
		ALU_SLT,
		ALU_SEQ
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		value_t a;
		value_t b;
		value_t c;
		tag_t tag;
	} alu_req_t;

	typedef struct packed {
		value_t a;
		value_t b;
		logic a_signed;
		logic b_signed;
		logic high;
		tag_t tag;
	} mul_req_t;

	typedef struct packed {
		tag_t tag;
		value_t val;
		logic ovf;
	} unit_res_t;

	typedef struct packed {
		tag_t tag;
		value_t val;
		logic ovf;
	} result_t;

endpackage

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
	input  wire logic             clk_g,
	input  wire logic             rst_i,
	input  wire logic             issue_stb_i,
	input  wire exec_pkg::issue_t issue_i,
	output      logic             result_stb_o,
	output      exec_pkg::result_t result_o
);

	logic alu_stb;
	exec_pkg::alu_req_t alu_req;
	logic mul_stb;
	exec_pkg::mul_req_t mul_req;
	logic alu_res_stb;
	exec_pkg::unit_res_t alu_res;
	logic mul_res_stb;
	exec_pkg::unit_res_t mul_res;

	operand_decode operand_decode_i (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.issue_stb_i (issue_stb_i),
		.issue_i     (issue_i),
		.alu_stb_o   (alu_stb),
		.alu_req_o   (alu_req),
		.mul_stb_o   (mul_stb),
		.mul_req_o   (mul_req)
	);

	// ALU and multiplier run side by side
	int_alu int_alu_i (
		.clk_g     (clk_g),
		.rst_i     (rst_i),
		.alu_stb_i (alu_stb),
		.alu_req_i (alu_req),
		.res_stb_o (alu_res_stb),
		.res_o     (alu_res)
	);

	mul_unit mul_unit_i (
		.clk_g     (clk_g),
		.rst_i     (rst_i),
		.mul_stb_i (mul_stb),
		.mul_req_i (mul_req),
		.res_stb_o (mul_res_stb),
		.res_o     (mul_res)
	);

	result_merge result_merge_i (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.alu_stb_i    (alu_res_stb),
		.alu_res_i    (alu_res),
		.mul_stb_i    (mul_res_stb),
		.mul_res_i    (mul_res),
		.result_stb_o (result_stb_o),
		.result_o     (result_o)
	);

endmodule

`default_nettype wire

// ==== rtl/int_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module int_alu (
	input  wire logic               clk_g,
	input  wire logic               rst_i,
	input  wire logic               alu_stb_i,
	input  wire exec_pkg::alu_req_t alu_req_i,
	output      logic               res_stb_o,
	output      exec_pkg::unit_res_t res_o
);

	// Decode and merge registers take two of the cycles
	localparam int DEPTH = `EXEC_LATENCY - 2;

	exec_pkg::value_t a;
	exec_pkg::value_t b;
	exec_pkg::value_t c;
	exec_pkg::value_t alu_val;
	logic lt_s;
	logic lt_u;
	logic eq;

	logic [DEPTH-1:0] stb_q;
	exec_pkg::unit_res_t res_q [DEPTH];

	assign a = alu_req_i.a;
	assign b = alu_req_i.b;
	assign c = alu_req_i.c;

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq = a == b;

	// ==============================
	// Operation select
	// ==============================

	always_comb begin
		case (alu_req_i.op)
			exec_pkg::ALU_ADD: alu_val = a + b + c;
			exec_pkg::ALU_SUB: alu_val = a - b;
			exec_pkg::ALU_AND: alu_val = a & b & c;
			exec_pkg::ALU_OR:  alu_val = a | b | c;
			exec_pkg::ALU_XOR: alu_val = a ^ b ^ c;
			// Bit from b where a is set, else from c
			exec_pkg::ALU_MUX: alu_val = (a & b) | (~a & c);
			// Three-way compare gives -1, 0 or 1
			exec_pkg::ALU_CMP: begin
				if (lt_s)
					alu_val = '1;
				else if (eq)
					alu_val = '0;
				else
					alu_val = exec_pkg::value_t'(1);
			end
			exec_pkg::ALU_CMPU: begin
				if (lt_u)
					alu_val = '1;
				else if (eq)
					alu_val = '0;
				else
					alu_val = exec_pkg::value_t'(1);
			end
			exec_pkg::ALU_SLT: alu_val = exec_pkg::value_t'(lt_s);
			exec_pkg::ALU_SEQ: alu_val = exec_pkg::value_t'(eq);
			default: alu_val = '0;
		endcase
	end

	// ==============================
	// Delay to common latency
	// ==============================

	always_ff @(posedge clk_g) begin
		if (rst_i)
			stb_q <= '0;
		else
			stb_q <= {stb_q[DEPTH-2:0], alu_stb_i};
	end

	always_ff @(posedge clk_g) begin
		res_q[0].tag <= alu_req_i.tag;
		res_q[0].val <= alu_val;
		res_q[0].ovf <= 1'b0;
		for (int i = 1; i < DEPTH; i++)
			res_q[i] <= res_q[i-1];
	end

	assign res_stb_o = stb_q[DEPTH-1];
	assign res_o = res_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== rtl/mul_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module mul_unit (
	input  wire logic               clk_g,
	input  wire logic               rst_i,
	input  wire logic               mul_stb_i,
	input  wire exec_pkg::mul_req_t mul_req_i,
	output      logic               res_stb_o,
	output      exec_pkg::unit_res_t res_o
);

	localparam int VW = `EXEC_VALUE_W;
	localparam int PROD_W = 2 * VW;

	typedef struct packed {
		exec_pkg::value_t mag_a;
		exec_pkg::value_t mag_b;
		logic neg;
		logic sgn;
		logic high;
		exec_pkg::tag_t tag;
	} s1_t;

	typedef struct packed {
		logic [PROD_W-1:0] prod;
		logic neg;
		logic sgn;
		logic high;
		exec_pkg::tag_t tag;
	} s2_t;

	logic a_neg;
	logic b_neg;
	s1_t s1_d;
	s1_t s1_q;
	s2_t s2_q;
	logic s1_stb;
	logic s2_stb;
	logic [PROD_W-1:0] prod_fix;
	logic [VW-1:0] prod_hi;
	logic [VW-1:0] prod_lo;
	logic ovf;

	// ==============================
	// Stage 1: magnitudes and sign
	// ==============================

	assign a_neg = mul_req_i.a_signed & mul_req_i.a[VW-1];
	assign b_neg = mul_req_i.b_signed & mul_req_i.b[VW-1];

	always_comb begin
		s1_d.mag_a = a_neg ? -mul_req_i.a : mul_req_i.a;
		s1_d.mag_b = b_neg ? -mul_req_i.b : mul_req_i.b;
		s1_d.neg = a_neg ^ b_neg;
		s1_d.sgn = mul_req_i.a_signed | mul_req_i.b_signed;
		s1_d.high = mul_req_i.high;
		s1_d.tag = mul_req_i.tag;
	end

	// ==============================
	// Stage 3: fix sign, select half
	// ==============================

	assign prod_fix = s2_q.neg ? -s2_q.prod : s2_q.prod;
	assign prod_hi = prod_fix[PROD_W-1:VW];
	assign prod_lo = prod_fix[VW-1:0];

	// Signed: high half must equal the sign of the low half
	assign ovf = s2_q.sgn ? (prod_hi != {VW{prod_lo[VW-1]}}) : (prod_hi != '0);

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s1_stb <= 1'b0;
			s2_stb <= 1'b0;
			res_stb_o <= 1'b0;
		end else begin
			s1_stb <= mul_stb_i;
			s2_stb <= s1_stb;
			res_stb_o <= s2_stb;
		end
	end

	always_ff @(posedge clk_g) begin
		s1_q <= s1_d;
		// Stage 2 full unsigned product
		s2_q.prod <= {{VW{1'b0}}, s1_q.mag_a} * {{VW{1'b0}}, s1_q.mag_b};
		s2_q.neg <= s1_q.neg;
		s2_q.sgn <= s1_q.sgn;
		s2_q.high <= s1_q.high;
		s2_q.tag <= s1_q.tag;
		res_o.tag <= s2_q.tag;
		res_o.val <= s2_q.high ? prod_hi : prod_lo;
		res_o.ovf <= ovf;
	end

endmodule

`default_nettype wire

// ==== rtl/operand_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module operand_decode (
	input  wire logic              clk_g,
	input  wire logic              rst_i,
	input  wire logic              issue_stb_i,
	input  wire exec_pkg::issue_t  issue_i,
	output      logic              alu_stb_o,
	output      exec_pkg::alu_req_t alu_req_o,
	output      logic              mul_stb_o,
	output      exec_pkg::mul_req_t mul_req_o
);

	exec_pkg::opcode_e opc;
	exec_pkg::value_t imm_ext;
	exec_pkg::alu_req_t alu_req_d;
	exec_pkg::mul_req_t mul_req_d;
	logic to_mul;

	assign opc = issue_i.insn.i_form.opcode;

	// Immediate is sign-extended to a full word
	assign imm_ext = {{(`EXEC_VALUE_W-`EXEC_IMM_W){issue_i.insn.i_form.imm[`EXEC_IMM_W-1]}},
		issue_i.insn.i_form.imm};

	always_comb begin
		alu_req_d.op = exec_pkg::ALU_ZERO;
		alu_req_d.a = issue_i.a;
		alu_req_d.b = issue_i.b;
		alu_req_d.c = issue_i.c;
		alu_req_d.tag = issue_i.insn.i_form.rt;
		mul_req_d.a = issue_i.a;
		mul_req_d.b = issue_i.b;
		mul_req_d.a_signed = 1'b1;
		mul_req_d.b_signed = 1'b1;
		mul_req_d.high = 1'b0;
		mul_req_d.tag = issue_i.insn.i_form.rt;
		to_mul = 1'b0;
		case (opc)
			exec_pkg::R2: begin
				case (issue_i.insn.r_form.func)
					exec_pkg::ADD: alu_req_d.op = exec_pkg::ALU_ADD;
					exec_pkg::SUB: alu_req_d.op = exec_pkg::ALU_SUB;
					exec_pkg::AND: alu_req_d.op = exec_pkg::ALU_AND;
					exec_pkg::OR:  alu_req_d.op = exec_pkg::ALU_OR;
					exec_pkg::XOR: alu_req_d.op = exec_pkg::ALU_XOR;
					exec_pkg::MUX: alu_req_d.op = exec_pkg::ALU_MUX;
					exec_pkg::MUL: to_mul = 1'b1;
					exec_pkg::MULH: begin
						to_mul = 1'b1;
						mul_req_d.high = 1'b1;
					end
					exec_pkg::MULU: begin
						to_mul = 1'b1;
						mul_req_d.a_signed = 1'b0;
						mul_req_d.b_signed = 1'b0;
					end
					exec_pkg::MULUH: begin
						to_mul = 1'b1;
						mul_req_d.a_signed = 1'b0;
						mul_req_d.b_signed = 1'b0;
						mul_req_d.high = 1'b1;
					end
					default: alu_req_d.op = exec_pkg::ALU_ZERO;
				endcase
			end
			// Third operand set to the identity of the op
			exec_pkg::ADDI: begin
				alu_req_d.op = exec_pkg::ALU_ADD;
				alu_req_d.b = imm_ext;
				alu_req_d.c = '0;
			end
			// Operands swapped, result is imm - a
			exec_pkg::SUBFI: begin
				alu_req_d.op = exec_pkg::ALU_SUB;
				alu_req_d.a = imm_ext;
				alu_req_d.b = issue_i.a;
			end
			exec_pkg::ANDI: begin
				alu_req_d.op = exec_pkg::ALU_AND;
				alu_req_d.b = imm_ext;
				alu_req_d.c = '1;
			end
			exec_pkg::ORI: begin
				alu_req_d.op = exec_pkg::ALU_OR;
				alu_req_d.b = imm_ext;
				alu_req_d.c = '0;
			end
			exec_pkg::XORI: begin
				alu_req_d.op = exec_pkg::ALU_XOR;
				alu_req_d.b = imm_ext;
				alu_req_d.c = '0;
			end
			exec_pkg::CMPI: begin
				alu_req_d.op = exec_pkg::ALU_CMP;
				alu_req_d.b = imm_ext;
			end
			exec_pkg::CMPUI: begin
				alu_req_d.op = exec_pkg::ALU_CMPU;
				alu_req_d.b = imm_ext;
			end
			exec_pkg::SLTI: begin
				alu_req_d.op = exec_pkg::ALU_SLT;
				alu_req_d.b = imm_ext;
			end
			exec_pkg::SEQI: begin
				alu_req_d.op = exec_pkg::ALU_SEQ;
				alu_req_d.b = imm_ext;
			end
			exec_pkg::MULI: begin
				to_mul = 1'b1;
				mul_req_d.b = imm_ext;
			end
			// Immediate still sign-extended, then taken as unsigned
			exec_pkg::MULUI: begin
				to_mul = 1'b1;
				mul_req_d.b = imm_ext;
				mul_req_d.a_signed = 1'b0;
				mul_req_d.b_signed = 1'b0;
			end
			default: alu_req_d.op = exec_pkg::ALU_ZERO;
		endcase
	end

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			alu_stb_o <= 1'b0;
			mul_stb_o <= 1'b0;
		end else begin
			alu_stb_o <= issue_stb_i & ~to_mul;
			mul_stb_o <= issue_stb_i & to_mul;
		end
	end

	always_ff @(posedge clk_g) begin
		if (issue_stb_i) begin
			alu_req_o <= alu_req_d;
			mul_req_o <= mul_req_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/result_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_merge (
	input  wire logic                clk_g,
	input  wire logic                rst_i,
	input  wire logic                alu_stb_i,
	input  wire exec_pkg::unit_res_t alu_res_i,
	input  wire logic                mul_stb_i,
	input  wire exec_pkg::unit_res_t mul_res_i,
	output      logic                result_stb_o,
	output      exec_pkg::result_t   result_o
);

	exec_pkg::unit_res_t sel;

	// Equal path latency, so only one unit strobes per cycle
	assign sel = mul_stb_i ? mul_res_i : alu_res_i;

	always_ff @(posedge clk_g) begin
		if (rst_i)
			result_stb_o <= 1'b0;
		else
			result_stb_o <= alu_stb_i | mul_stb_i;
	end

	always_ff @(posedge clk_g) begin
		if (alu_stb_i | mul_stb_i) begin
			result_o.tag <= sel.tag;
			result_o.val <= sel.val;
			result_o.ovf <= sel.ovf;
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/exec_pkg.sv
rtl/operand_decode.sv
rtl/int_alu.sv
rtl/mul_unit.sv
rtl/result_merge.sv
rtl/exec_unit.sv
dv/clk_gen.sv
dv/exec_unit_tb.sv
